// File: design/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Boot vector in kseg1, fetched right after reset
`define MIPS_RESET_PC 32'hbfc00000

// Architectural integer registers
`define MIPS_NREGS 32

`endif

// File: design/mips_pkg.sv
package mips_pkg;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_sltiu = 6'h0b;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        // Places the low immediate half in the upper 16 bits
        alu_lui  = 4'd8
    } alu_op_e;

endpackage

// File: design/controller.sv
`timescale 1ns/100ps

module controller import mips_pkg::*; (
    input  logic [31:0] instr,
    output alu_op_e     alu_op,
    output logic        alu_src_imm,
    output logic        imm_zero_ext,
    output logic        reg_write,
    output logic        reg_dst_rt,
    output logic        mem_read,
    output logic        mem_write,
    output logic        branch_eq,
    output logic        branch_ne,
    output logic        jump
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // Defaults describe a no-op
        alu_op       = alu_add;
        alu_src_imm  = 1'b0;
        imm_zero_ext = 1'b0;
        reg_write    = 1'b0;
        reg_dst_rt   = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        branch_eq    = 1'b0;
        branch_ne    = 1'b0;
        jump         = 1'b0;

        case (opcode)
            op_rtype: begin
                reg_write = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:  alu_op = alu_sll;
                    default: reg_write = 1'b0;
                endcase
            end
            op_addiu, op_sltiu, op_andi, op_ori, op_lui: begin
                reg_write   = 1'b1;
                reg_dst_rt  = 1'b1;
                alu_src_imm = 1'b1;
                imm_zero_ext = (opcode == op_andi) || (opcode == op_ori);
                case (opcode)
                    op_sltiu: alu_op = alu_sltu;
                    op_andi:  alu_op = alu_and;
                    op_ori:   alu_op = alu_or;
                    op_lui:   alu_op = alu_lui;
                    default:  alu_op = alu_add;
                endcase
            end
            op_lw: begin
                reg_write   = 1'b1;
                reg_dst_rt  = 1'b1;
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
            end
            op_sw: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            op_beq:  branch_eq = 1'b1;
            op_bne:  branch_ne = 1'b1;
            op_j:    jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: design/hazard.sv
`timescale 1ns/100ps

module hazard (
    input  logic [4:0] rs_d,
    input  logic [4:0] rt_d,
    input  logic [4:0] write_reg_w,
    input  logic       reg_write_w,
    input  logic       stall_by_sram,
    output logic       fwd_rs,
    output logic       fwd_rt,
    output logic       en
);

    logic w_live;

    // W carries a real register update, r0 never forwards
    assign w_live = reg_write_w && (write_reg_w != 5'd0);

    // The W result is either load data or the ALU result, so one
    // bypass path covers load-use as well as back-to-back ALU use
    assign fwd_rs = w_live && (write_reg_w == rs_d);
    assign fwd_rt = w_live && (write_reg_w == rt_d);

    // Every stage holds while the memory side is busy
    assign en = ~stall_by_sram;

endmodule

// File: design/regfile.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    // Reads are combinational, r0 is hardwired
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: design/datapath.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module datapath import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  alu_op_e     alu_op,
    input  logic        alu_src_imm,
    input  logic        imm_zero_ext,
    input  logic        reg_write,
    input  logic        reg_dst_rt,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic        branch_eq,
    input  logic        branch_ne,
    input  logic        jump,
    input  logic        fwd_rs,
    input  logic        fwd_rt,
    output logic [31:0] instr_d,
    output logic [4:0]  rs_d,
    output logic [4:0]  rt_d,
    output logic [4:0]  write_reg_w,
    output logic        reg_write_w,
    output logic [31:0] pc,
    output logic        instr_en,
    input  logic [31:0] instr,
    output logic [31:0] mem_addr,
    output logic [31:0] write_data,
    output logic        mem_en,
    output logic [3:0]  mem_write_en,
    input  logic [31:0] read_data,
    output logic [31:0] pc_w,
    output logic [31:0] reg_write_data_w
);

    logic [31:0] pc_f, pc_next, pc_d, pc_plus4_d;
    logic [31:0] branch_target, jump_target;
    logic        valid_d, valid_w, take_branch;
    logic [31:0] rd1, rd2, src_a, rt_val, src_b, imm_ext, alu_result;
    logic [4:0]  write_reg_d;
    logic        reg_write_q, mem_read_w;
    logic [31:0] alu_w, result_w;

    // F stage, fetch goes out on the physical address
    assign pc       = {3'b000, pc_f[28:0]};
    assign instr_en = ~reset;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_f    <= `MIPS_RESET_PC;
            valid_d <= 1'b0;
        end else if (en) begin
            pc_f    <= pc_next;
            valid_d <= instr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            pc_d <= pc_f;
        end
    end

    // D stage, an empty slot decodes as sll r0,r0,0
    assign instr_d     = valid_d ? instr : 32'd0;
    assign rs_d        = instr_d[25:21];
    assign rt_d        = instr_d[20:16];
    assign write_reg_d = reg_dst_rt ? rt_d : instr_d[15:11];
    assign imm_ext     = imm_zero_ext ? {16'd0, instr_d[15:0]}
                                      : {{16{instr_d[15]}}, instr_d[15:0]};

    assign src_a  = fwd_rs ? result_w : rd1;
    assign rt_val = fwd_rt ? result_w : rd2;
    assign src_b  = alu_src_imm ? imm_ext : rt_val;

    always_comb begin
        case (alu_op)
            alu_sub:  alu_result = src_a - src_b;
            alu_and:  alu_result = src_a & src_b;
            alu_or:   alu_result = src_a | src_b;
            alu_xor:  alu_result = src_a ^ src_b;
            alu_slt:  alu_result = {31'd0, $signed(src_a) < $signed(src_b)};
            alu_sltu: alu_result = {31'd0, src_a < src_b};
            alu_sll:  alu_result = src_b << instr_d[10:6];
            alu_lui:  alu_result = {src_b[15:0], 16'd0};
            default:  alu_result = src_a + src_b;
        endcase
    end

    // The instruction in F is the delay slot, so a redirect lands after it
    assign take_branch   = (branch_eq && (src_a == rt_val)) || (branch_ne && (src_a != rt_val));
    assign pc_plus4_d    = pc_d + 32'd4;
    assign branch_target = pc_plus4_d + {imm_ext[29:0], 2'b00};
    assign jump_target   = {pc_plus4_d[31:28], instr_d[25:0], 2'b00};
    assign pc_next       = jump ? jump_target : (take_branch ? branch_target : pc_f + 32'd4);

    assign mem_addr     = {3'b000, alu_result[28:0]};
    assign write_data   = rt_val;
    assign mem_en       = mem_read | mem_write;
    assign mem_write_en = {4{mem_write}};

    // W stage
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_w     <= 1'b0;
            reg_write_q <= 1'b0;
            mem_read_w  <= 1'b0;
        end else if (en) begin
            valid_w     <= valid_d;
            reg_write_q <= reg_write && (write_reg_d != 5'd0);
            mem_read_w  <= mem_read;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            pc_w        <= pc_d;
            write_reg_w <= write_reg_d;
            alu_w       <= alu_result;
        end
    end

    assign result_w         = mem_read_w ? read_data : alu_w;
    assign reg_write_w      = valid_w & reg_write_q & en;
    assign reg_write_data_w = result_w;

    regfile regfile_i (
        .clk   (clk),
        .reset (reset),
        .we    (reg_write_w),
        .ra1   (rs_d),
        .ra2   (rt_d),
        .wa    (write_reg_w),
        .wd    (result_w),
        .rd1   (rd1),
        .rd2   (rd2)
    );

endmodule

// File: design/mips.sv
`timescale 1ns/100ps

module mips (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_by_sram,

    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,

    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,

    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    mips_pkg::alu_op_e alu_op;
    logic        alu_src_imm, imm_zero_ext, reg_write, reg_dst_rt;
    logic        mem_read, mem_write, branch_eq, branch_ne, jump;
    logic        fwd_rs, fwd_rt, en, reg_write_w;
    logic [31:0] instr_d;
    logic [4:0]  rs_d, rt_d;

    // Instruction memory is read only
    assign inst_sram_wen   = 4'b0;
    assign inst_sram_wdata = 32'b0;

    assign debug_wb_rf_wen = {4{reg_write_w}};

    datapath datapath_i (
        .clk(clk), .reset(reset), .en(en),
        .alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
        .reg_write(reg_write), .reg_dst_rt(reg_dst_rt),
        .mem_read(mem_read), .mem_write(mem_write),
        .branch_eq(branch_eq), .branch_ne(branch_ne), .jump(jump),
        .fwd_rs(fwd_rs), .fwd_rt(fwd_rt),
        .instr_d(instr_d), .rs_d(rs_d), .rt_d(rt_d),
        .write_reg_w(debug_wb_rf_wnum), .reg_write_w(reg_write_w),
        .pc(inst_sram_addr), .instr_en(inst_sram_en), .instr(inst_sram_rdata),
        .mem_addr(data_sram_addr), .write_data(data_sram_wdata),
        .mem_en(data_sram_en), .mem_write_en(data_sram_wen),
        .read_data(data_sram_rdata),
        .pc_w(debug_wb_pc), .reg_write_data_w(debug_wb_rf_wdata)
    );

    controller controller_i (
        .instr(instr_d), .alu_op(alu_op),
        .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
        .reg_write(reg_write), .reg_dst_rt(reg_dst_rt),
        .mem_read(mem_read), .mem_write(mem_write),
        .branch_eq(branch_eq), .branch_ne(branch_ne), .jump(jump)
    );

    hazard hazard_i (
        .rs_d(rs_d), .rt_d(rt_d),
        .write_reg_w(debug_wb_rf_wnum), .reg_write_w(reg_write_w),
        .stall_by_sram(stall_by_sram),
        .fwd_rs(fwd_rs), .fwd_rt(fwd_rt), .en(en)
    );

endmodule

// File: test/mips_assertions.sv
`timescale 1ns/100ps

module mips_assertions (
    input logic        clk,
    input logic        reset,
    input logic        stall_by_sram,
    input logic        inst_sram_en,
    input logic [31:0] inst_sram_addr,
    input logic        data_sram_en,
    input logic [3:0]  data_sram_wen,
    input logic [31:0] debug_wb_pc,
    input logic [3:0]  debug_wb_rf_wen,
    input logic [4:0]  debug_wb_rf_wnum,
    input logic [31:0] debug_wb_rf_wdata
);

    int unsigned fail_count = 0;

    fetch_off_in_reset: assert property (@(posedge clk) reset |-> !inst_sram_en) else begin
        fail_count++;
        $error("instruction fetch enabled while reset is high");
    end

    // Stage registers clear on the reset edge, so quiet outputs follow one cycle later
    quiet_in_reset: assert property (@(posedge clk)
        reset |=> !data_sram_en && debug_wb_rf_wen == 4'h0) else begin
        fail_count++;
        $error("data access or trace write while reset is high");
    end

    hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        stall_by_sram |=> $stable(inst_sram_addr) && $stable(debug_wb_pc)
            && $stable(debug_wb_rf_wnum) && $stable(debug_wb_rf_wdata)) else begin
        fail_count++;
        $error("fetch address or trace moved during a stall");
    end

    wen_needs_en: assert property (@(posedge clk) disable iff (reset)
        data_sram_wen != 4'h0 |-> data_sram_en) else begin
        fail_count++;
        $error("data write enable without data access enable");
    end

    no_r0_trace: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != 5'd0) else begin
        fail_count++;
        $error("trace write names register 0");
    end

endmodule

bind mips mips_assertions mips_assertions_i (.*);

// File: test/mips_tb.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_tb import mips_pkg::*; ();

    localparam int timeout_cycles = 3000;

    logic        clk;
    logic        reset;
    logic        stall_by_sram;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    logic [31:0] dmem_exp [1024];
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_num [$];
    logic [31:0] exp_data [$];
    int          error_count;
    int          tests_run;
    int          tests_failed;

    mips dut_i (.*);

    always #2 clk = ~clk;

    // Both memories answer one cycle after the request and freeze on a stall
    always @(posedge clk) begin
        if (!stall_by_sram && inst_sram_en) begin
            check_value("inst_sram_addr[31:12]", 32'(inst_sram_addr[31:12]), 32'h1fc00, $time);
            check_value("inst_sram_wen", 32'(inst_sram_wen), 32'h0, $time);
            check_value("inst_sram_wdata", inst_sram_wdata, 32'h0, $time);
            inst_sram_rdata <= imem[inst_sram_addr[11:2]];
        end
    end

    always @(posedge clk) begin
        if (!stall_by_sram && data_sram_en) begin
            check_value("data_sram_addr[31:12]", 32'(data_sram_addr[31:12]), 32'h0, $time);
            if (data_sram_wen == 4'hf) begin
                dmem[data_sram_addr[11:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= dmem[data_sram_addr[11:2]];
        end
    end

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] sa);
        return {op_rtype, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_to(input logic [31:0] target);
        return {op_j, target[27:2]};
    endfunction

    function automatic logic [31:0] addr_of(input int idx);
        return `MIPS_RESET_PC + 32'(idx) * 32'd4;
    endfunction

    // Virtual to physical clears the top three bits, the models hold 4 KB
    function automatic logic [9:0] word_index(input logic [31:0] vaddr);
        logic [31:0] paddr;
        paddr = vaddr & 32'h1fffffff;
        return paddr[11:2];
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] paddr);
        return (paddr * 32'h9e3779b1) ^ 32'h5ca1ab1e;
    endfunction

    function automatic int total_errors();
        return error_count + int'(dut_i.mips_assertions_i.fail_count);
    endfunction

    task automatic check_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp, input time t);
        assert (got === exp) else begin
            error_count++;
            $display("FAILED t=%0t %s: got %h expected %h", t, sig, got, exp);
        end
    endtask

    task automatic load_memories();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
            dmem[i] <= fill_word(32'(i) << 2);
        end
    endtask

    // Instruction-level model with one delay slot after every branch or jump
    task automatic predict_trace();
        logic [31:0] regs [`MIPS_NREGS];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] target;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] val;
        logic [4:0]  dst;
        int          idx;
        exp_pc = {};
        exp_num = {};
        exp_data = {};
        for (int i = 0; i < `MIPS_NREGS; i++) begin
            regs[i] = 32'h0;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem_exp[i] = fill_word(32'(i) << 2);
        end
        pc = `MIPS_RESET_PC;
        npc = pc + 32'd4;
        for (int step = 0; step < 1000; step++) begin
            idx = int'((pc - `MIPS_RESET_PC) >> 2);
            ins = (idx < prog.size()) ? prog[idx] : 32'h0;
            if (ins == jump_to(pc)) begin
                break;
            end
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            dst = 5'd0;
            val = 32'h0;
            target = npc + 32'd4;
            case (ins[31:26])
                op_rtype: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        fn_addu: val = a + b;
                        fn_subu: val = a - b;
                        fn_and:  val = a & b;
                        fn_or:   val = a | b;
                        fn_xor:  val = a ^ b;
                        fn_slt:  val = 32'($signed(a) < $signed(b));
                        fn_sltu: val = 32'(a < b);
                        fn_sll:  val = b << ins[10:6];
                        default: dst = 5'd0;
                    endcase
                end
                op_addiu: val = a + simm;
                op_sltiu: val = 32'(a < simm);
                op_andi:  val = a & {16'h0, ins[15:0]};
                op_ori:   val = a | {16'h0, ins[15:0]};
                op_lui:   val = {ins[15:0], 16'h0};
                op_lw:    val = dmem_exp[word_index(a + simm)];
                op_sw:    dmem_exp[word_index(a + simm)] = b;
                op_beq:   if (a == b) target = pc + 32'd4 + (simm << 2);
                op_bne:   if (a != b) target = pc + 32'd4 + (simm << 2);
                op_j:     target = ((pc + 32'd4) & 32'hf0000000) | {4'h0, ins[25:0], 2'b00};
                default:  ;
            endcase
            if (ins[31:26] inside {op_addiu, op_sltiu, op_andi, op_ori, op_lui, op_lw}) begin
                dst = ins[20:16];
            end
            if (dst != 5'd0) begin
                regs[dst] = val;
                exp_pc.push_back(pc);
                exp_num.push_back(32'(dst));
                exp_data.push_back(val);
            end
            pc = npc;
            npc = target;
        end
    endtask

    task automatic run_program(input string name, input bit stalled);
        logic [31:0] got_pc [$];
        logic [31:0] got_num [$];
        logic [31:0] got_data [$];
        time         got_t [$];
        int          cycles;
        int          errors_before;
        errors_before = total_errors();
        // Every program ends spinning on a jump to itself
        prog.push_back(jump_to(addr_of(prog.size())));
        prog.push_back(32'h0);
        predict_trace();
        @(posedge clk);
        reset <= 1'b1;
        stall_by_sram <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_value("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0, $time);
            end
            if (i == 2) begin
                load_memories();
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        check_value("inst_sram_en", 32'(inst_sram_en), 32'h1, $time);
        check_value("inst_sram_addr", inst_sram_addr, `MIPS_RESET_PC & 32'h1fffffff, $time);
        cycles = 0;
        while (got_pc.size() < exp_pc.size() && cycles < timeout_cycles) begin
            stall_by_sram <= stalled && ($urandom_range(3, 0) == 0);
            @(posedge clk);
            cycles++;
            if (debug_wb_rf_wen != 4'h0) begin
                got_pc.push_back(debug_wb_pc);
                got_num.push_back(32'(debug_wb_rf_wnum));
                got_data.push_back(debug_wb_rf_wdata);
                got_t.push_back($time);
            end
        end
        stall_by_sram <= 1'b0;
        if (got_pc.size() < exp_pc.size()) begin
            error_count++;
            $display("Timeout in test %s: only %0d of %0d trace entries after %0d cycles",
                     name, got_pc.size(), exp_pc.size(), cycles);
        end
        for (int i = 0; i < got_pc.size(); i++) begin
            check_value($sformatf("debug_wb_pc[%0d]", i), got_pc[i], exp_pc[i], got_t[i]);
            check_value($sformatf("debug_wb_rf_wnum[%0d]", i), got_num[i], exp_num[i], got_t[i]);
            check_value($sformatf("debug_wb_rf_wdata[%0d]", i), got_data[i], exp_data[i],
                        got_t[i]);
        end
        @(negedge clk);
        for (int i = 0; i < 1024; i++) begin
            check_value($sformatf("dmem[%h]", i * 4), dmem[i], dmem_exp[i], $time);
        end
        tests_run++;
        if (total_errors() != errors_before) begin
            tests_failed++;
        end
        $display("test %s: %0d trace entries, %0d cycles, %0d errors",
                 name, got_pc.size(), cycles, total_errors() - errors_before);
    endtask

    task automatic alu_sequence(input bit stalled);
        prog = '{
            itype(op_lui, 1, 0, 16'h1234),
            itype(op_ori, 1, 1, 16'h5678),
            itype(op_addiu, 2, 1, 16'hffff),
            rtype(fn_addu, 3, 1, 2, 0),
            rtype(fn_subu, 4, 3, 1, 0),
            rtype(fn_and, 5, 4, 3, 0),
            rtype(fn_or, 6, 5, 1, 0),
            rtype(fn_xor, 7, 6, 2, 0),
            rtype(fn_slt, 8, 7, 1, 0),
            rtype(fn_sltu, 9, 1, 7, 0),
            rtype(fn_sll, 10, 0, 9, 7),
            itype(op_addiu, 11, 0, 16'hfffb),
            rtype(fn_slt, 12, 11, 0, 0),
            rtype(fn_sltu, 13, 11, 0, 0),
            itype(op_sltiu, 14, 11, 16'hffff),
            itype(op_andi, 15, 11, 16'hff0f)
        };
        run_program(stalled ? "alu with stalls" : "alu", stalled);
    endtask

    task automatic load_store(input bit stalled);
        prog = '{
            itype(op_lui, 1, 0, 16'h8000),
            itype(op_ori, 1, 1, 16'h0100),
            itype(op_lui, 2, 0, 16'ha000),
            itype(op_addiu, 3, 0, 16'h1234),
            itype(op_sw, 3, 1, 16'h0000),
            itype(op_lw, 4, 1, 16'h0000),
            rtype(fn_addu, 5, 4, 4, 0),
            itype(op_lw, 6, 1, 16'h0008),
            itype(op_sw, 6, 2, 16'h0004),
            itype(op_lw, 7, 2, 16'h0004),
            itype(op_addiu, 8, 7, 16'h0001),
            itype(op_sw, 8, 1, 16'hfffc),
            itype(op_addiu, 9, 0, 16'h0009)
        };
        run_program(stalled ? "load/store with stalls" : "load/store", stalled);
    endtask

    task automatic branch_and_jump(input bit stalled);
        prog = '{
            itype(op_addiu, 1, 0, 16'd5),
            itype(op_addiu, 2, 0, 16'd5),
            itype(op_beq, 2, 1, 16'd2),
            itype(op_addiu, 3, 0, 16'd1),
            itype(op_addiu, 3, 0, 16'd2),
            itype(op_bne, 2, 1, 16'd1),
            itype(op_addiu, 4, 0, 16'd3),
            itype(op_addiu, 5, 0, 16'd4),
            itype(op_beq, 0, 1, 16'd1),
            itype(op_addiu, 6, 0, 16'd6),
            itype(op_bne, 0, 1, 16'd2),
            itype(op_addiu, 7, 0, 16'd7),
            itype(op_addiu, 7, 0, 16'd99),
            jump_to(addr_of(16)),
            itype(op_addiu, 8, 0, 16'd8),
            itype(op_addiu, 8, 0, 16'd77),
            itype(op_addiu, 9, 0, 16'd9)
        };
        run_program(stalled ? "branch/jump with stalls" : "branch/jump", stalled);
    endtask

    task automatic reset_behavior();
        prog = '{
            32'h0,
            rtype(fn_sltu, 0, 0, 0, 0),
            32'h0,
            itype(op_addiu, 1, 0, 16'h0077),
            itype(op_addiu, 2, 1, 16'h0001)
        };
        run_program("reset", 1'b0);
    endtask

    task automatic unknown_opcodes();
        prog = '{
            itype(op_addiu, 1, 0, 16'h0055),
            itype(6'h3f, 1, 1, 16'hffff),
            rtype(6'h18, 1, 1, 1, 0),
            itype(6'h08, 1, 1, 16'h0001),
            itype(6'h20, 1, 0, 16'h0000),
            itype(6'h28, 1, 0, 16'h0000),
            itype(op_addiu, 0, 0, 16'h1234),
            rtype(fn_addu, 0, 1, 1, 0),
            rtype(fn_addu, 2, 1, 0, 0),
            itype(op_addiu, 3, 0, 16'h0001)
        };
        run_program("unknown instructions", 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        reset <= 1'b1;
        stall_by_sram <= 1'b0;
        inst_sram_rdata <= 32'h0;
        data_sram_rdata <= 32'h0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'h8a23));
        alu_sequence(1'b0);
        load_store(1'b0);
        branch_and_jump(1'b0);
        reset_behavior();
        unknown_opcodes();
        // Same programs again with the memory side stalling at random
        alu_sequence(1'b1);
        load_store(1'b1);
        branch_and_jump(1'b1);
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+design
design/mips_pkg.sv
design/controller.sv
design/hazard.sv
design/regfile.sv
design/datapath.sv
design/mips.sv
test/mips_assertions.sv
test/mips_tb.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - design

sources:
  - design/mips_pkg.sv
  - design/controller.sv
  - design/hazard.sv
  - design/regfile.sv
  - design/datapath.sv
  - design/mips.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/mips_assertions.sv
      - test/mips_tb.sv
